/* warp_issue.f */
hw/issue_pkg.sv
hw/exec_pkg.sv
hw/queue_ptrs.sv
hw/bundle_queue.sv
hw/scoreboard.sv
hw/dispatch_fsm.sv
hw/unit_port.sv
hw/warp_issue_top.sv
tb/tb_warp_issue.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module tb_warp_issue -f warp_issue.f -o sim_warp_issue
	./obj_dir/sim_warp_issue | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb/tb_warp_issue.sv */
`timescale 1ns/100ps

module tb_warp_issue;

    import issue_pkg::*;
    import exec_pkg::*;

    localparam int LOG_DEPTH = 2;
    localparam int NUM_PAIRS = 64;
    localparam int NUM_INSTR = 2 * NUM_PAIRS;
    localparam int QUEUE_CAP = 2 ** LOG_DEPTH - 1;

    logic                clk;
    logic                rst_n;
    logic                wen;
    pair_t               pair_in;
    logic                arith_ready;
    logic                logic_ready;
    logic [NUM_REGS-1:0] retire0;
    logic [NUM_REGS-1:0] retire1;
    logic                full;
    logic                arith_valid;
    arith_payload_t      arith_out;
    logic                logic_valid;
    logic_payload_t      logic_out;

    // instructions in program order where index 2p is slot0 of pair p and 2p+1 its slot1
    bundle_t prog [NUM_INSTR];
    int      arith_list [NUM_INSTR];
    int      logic_list [NUM_INSTR];
    int      arith_total;
    int      logic_total;

    // reference model state is updated on the clock edge
    int                  arith_head;
    int                  logic_head;
    logic                done [NUM_INSTR];
    logic [NUM_REGS-1:0] lag_resv;
    logic [NUM_REGS-1:0] lag_retire;
    logic [NUM_REGS-1:0] seen_rd;
    int                  pairs_in;
    int                  pairs_out;
    int                  issued;

    int          lcg_state;
    int          flight [NUM_REGS];
    int          written;
    int          payload_errs;
    int          hazard_errs;
    int          order_errs;
    int          flow_errs;

    int             arith_idx;
    int             logic_idx;
    arith_payload_t exp_arith;
    logic_payload_t exp_logic;
    logic           arith_blocked;
    logic           logic_blocked;
    logic           early_slot1;
    logic           pair_clash;
    logic           exp_full;

    warp_issue_top #(.LOG_DEPTH(LOG_DEPTH)) dut_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_wen         (wen),
        .i_pair        (pair_in),
        .i_arith_ready (arith_ready),
        .i_logic_ready (logic_ready),
        .i_retire0     (retire0),
        .i_retire1     (retire1),
        .o_full        (full),
        .o_arith_valid (arith_valid),
        .o_arith       (arith_out),
        .o_logic_valid (logic_valid),
        .o_logic       (logic_out)
    );

    always #2 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // only the upper bits are used because the low bits of this generator repeat quickly
    function automatic int unsigned rand_below(input int unsigned n);
        return (lcg_next() >> 16) % n;
    endfunction

    function automatic bundle_t random_bundle();
        bundle_t     b;
        int unsigned hi;
        int unsigned lo;
        hi               = lcg_next();
        lo               = lcg_next();
        // registers are drawn from x0..x7 so that hazards are frequent
        b.rs1            = 5'(rand_below(8));
        b.rs2            = 5'(rand_below(8));
        b.rd             = 5'(rand_below(8));
        b.imm32          = {hi[31:16], lo[31:16]};
        b.unit           = unit_e'(rand_below(2));
        b.op2_is_imm     = (rand_below(2) == 1);
        b.rd_wen         = (rand_below(4) != 0);
        b.arith_opsel    = 3'(rand_below(8));
        b.arith_sub      = (rand_below(2) == 1);
        b.arith_unsigned = (rand_below(2) == 1);
        b.arith_word     = (rand_below(2) == 1);
        b.logic_opsel    = 3'(rand_below(8));
        b.logic_invert   = (rand_below(2) == 1);
        b.logic_word     = (rand_below(2) == 1);
        return b;
    endfunction

    function automatic logic [NUM_REGS-1:0] regs_used(input bundle_t b);
        logic [NUM_REGS-1:0] m;
        m        = '0;
        m[b.rs1] = 1'b1;
        m[b.rd]  = 1'b1;
        if (!b.op2_is_imm) begin
            m[b.rs2] = 1'b1;
        end
        m[0] = 1'b0;
        return m;
    endfunction

    // true when slot1 has to wait for slot0 of the same pair to be gone
    function automatic logic slot_conflict(input bundle_t s0, input bundle_t s1);
        logic reads;
        reads = (s1.rs1 == s0.rd) || (!s1.op2_is_imm && (s1.rs2 == s0.rd));
        return (s1.rd == s0.rd) || ((s0.rd != 5'd0) && reads);
    endfunction

    function automatic arith_payload_t expect_arith(input bundle_t b, input logic slot);
        arith_payload_t p;
        p.imm         = XLEN'($signed(b.imm32));
        p.opsel       = b.arith_opsel;
        p.sub         = b.arith_sub;
        p.unsigned_op = b.arith_unsigned;
        p.word        = b.arith_word;
        p.op2_is_imm  = b.op2_is_imm;
        p.rd          = b.rd;
        p.rd_wen      = b.rd_wen;
        p.banksel     = slot;
        return p;
    endfunction

    function automatic logic_payload_t expect_logic(input bundle_t b, input logic slot);
        logic_payload_t p;
        p.imm        = XLEN'($signed(b.imm32));
        p.opsel      = b.logic_opsel;
        p.invert     = b.logic_invert;
        p.word       = b.logic_word;
        p.op2_is_imm = b.op2_is_imm;
        p.rd         = b.rd;
        p.rd_wen     = b.rd_wen;
        p.banksel    = slot;
        return p;
    endfunction

    always_comb begin
        arith_idx     = (arith_head < arith_total) ? arith_list[arith_head] : 0;
        logic_idx     = (logic_head < logic_total) ? logic_list[logic_head] : 0;
        exp_arith     = expect_arith(prog[arith_idx], arith_idx[0]);
        exp_logic     = expect_logic(prog[logic_idx], logic_idx[0]);
        arith_blocked = |(lag_resv & regs_used(prog[arith_idx]));
        logic_blocked = |(lag_resv & regs_used(prog[logic_idx]));
        early_slot1   = (arith_valid && arith_idx[0] && !done[arith_idx - 1] &&
                         !(logic_valid && (logic_idx == arith_idx - 1))) ||
                        (logic_valid && logic_idx[0] && !done[logic_idx - 1] &&
                         !(arith_valid && (arith_idx == logic_idx - 1)));
        pair_clash    = arith_valid && logic_valid && (arith_idx / 2 == logic_idx / 2) &&
                        slot_conflict(prog[(arith_idx / 2) * 2], prog[(arith_idx / 2) * 2 + 1]);
        // a pair popped on the last edge only shows up as a slot1 valid now
        exp_full      = (pairs_in - pairs_out - (arith_valid && arith_idx[0] ? 1 : 0) -
                         (logic_valid && logic_idx[0] ? 1 : 0)) == QUEUE_CAP;
    end

    // the reservation copy lags one cycle because a valid now means a transmit last cycle
    always @(posedge clk or negedge rst_n) begin : model_update
        logic [NUM_REGS-1:0] fresh;
        int                  popped;
        int                  taken;
        if (!rst_n) begin
            arith_head <= 0;
            logic_head <= 0;
            lag_resv   <= '0;
            lag_retire <= '0;
            seen_rd    <= '0;
            pairs_in   <= 0;
            pairs_out  <= 0;
            issued     <= 0;
            for (int i = 0; i < NUM_INSTR; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            fresh  = '0;
            popped = 0;
            taken  = 0;
            if (arith_valid && (arith_head < arith_total)) begin
                done[arith_idx]           <= 1'b1;
                fresh[prog[arith_idx].rd] = 1'b1;
                popped                    = popped + (arith_idx % 2);
                taken                     = taken + 1;
                arith_head                <= arith_head + 1;
            end
            if (logic_valid && (logic_head < logic_total)) begin
                done[logic_idx]           <= 1'b1;
                fresh[prog[logic_idx].rd] = 1'b1;
                popped                    = popped + (logic_idx % 2);
                taken                     = taken + 1;
                logic_head                <= logic_head + 1;
            end
            fresh[0]   = 1'b0;
            lag_resv   <= (lag_resv & ~lag_retire) | fresh;
            lag_retire <= retire0 | retire1;
            seen_rd    <= fresh;
            pairs_in   <= pairs_in + (wen ? 1 : 0);
            pairs_out  <= pairs_out + popped;
            issued     <= issued + taken;
        end
    end

    a_arith_payload: assert property (@(posedge clk) disable iff (!rst_n)
        arith_valid |-> (arith_head < arith_total) && (arith_out == exp_arith))
        else begin
            payload_errs = payload_errs + 1;
            if ($sampled(arith_head) >= arith_total) begin
                $display("t=%0t: arith valid with no arith instruction left", $time);
            end else begin
                $display("MISMATCH t=%0t o_arith exp=%h got=%h",
                         $time, $sampled(exp_arith), $sampled(arith_out));
            end
        end

    a_logic_payload: assert property (@(posedge clk) disable iff (!rst_n)
        logic_valid |-> (logic_head < logic_total) && (logic_out == exp_logic))
        else begin
            payload_errs = payload_errs + 1;
            if ($sampled(logic_head) >= logic_total) begin
                $display("t=%0t: logic valid with no logic instruction left", $time);
            end else begin
                $display("MISMATCH t=%0t o_logic exp=%h got=%h",
                         $time, $sampled(exp_logic), $sampled(logic_out));
            end
        end

    a_arith_hazard: assert property (@(posedge clk) disable iff (!rst_n)
        arith_valid |-> !arith_blocked)
        else begin
            hazard_errs = hazard_errs + 1;
            $display("t=%0t: instruction %0d reached the arith unit with a reserved register",
                     $time, $sampled(arith_idx));
        end

    a_logic_hazard: assert property (@(posedge clk) disable iff (!rst_n)
        logic_valid |-> !logic_blocked)
        else begin
            hazard_errs = hazard_errs + 1;
            $display("t=%0t: instruction %0d reached the logic unit with a reserved register",
                     $time, $sampled(logic_idx));
        end

    a_slot_order: assert property (@(posedge clk) disable iff (!rst_n) !early_slot1)
        else begin
            order_errs = order_errs + 1;
            $display("t=%0t: slot1 dispatched before slot0 of its pair", $time);
        end

    a_pair_clash: assert property (@(posedge clk) disable iff (!rst_n) !pair_clash)
        else begin
            order_errs = order_errs + 1;
            $display("t=%0t: dependent slots of one pair dispatched in the same cycle", $time);
        end

    a_arith_ready: assert property (@(posedge clk) disable iff (!rst_n)
        arith_valid |-> $past(arith_ready))
        else begin
            flow_errs = flow_errs + 1;
            $display("t=%0t: arith valid after a cycle with arith ready low", $time);
        end

    a_logic_ready: assert property (@(posedge clk) disable iff (!rst_n)
        logic_valid |-> $past(logic_ready))
        else begin
            flow_errs = flow_errs + 1;
            $display("t=%0t: logic valid after a cycle with logic ready low", $time);
        end

    a_full_flag: assert property (@(posedge clk) disable iff (!rst_n) full == exp_full)
        else begin
            flow_errs = flow_errs + 1;
            $display("MISMATCH t=%0t o_full exp=%0b got=%0b",
                     $time, $sampled(exp_full), $sampled(full));
        end

    // one cycle of stimulus with retires first, then ready, then the next write
    task automatic step(input logic arith_rdy, input logic logic_rdy);
        logic [NUM_REGS-1:0] ret_a;
        logic [NUM_REGS-1:0] ret_b;
        @(posedge clk);
        #0.5;
        ret_a = '0;
        ret_b = '0;
        for (int r = 1; r < NUM_REGS; r++) begin
            if (seen_rd[r]) begin
                flight[r] = 1 + int'(rand_below(4));
            end else if (flight[r] > 0) begin
                flight[r] = flight[r] - 1;
                if (flight[r] == 0 && rand_below(2) == 0) begin
                    ret_a[r] = 1'b1;
                end else if (flight[r] == 0) begin
                    ret_b[r] = 1'b1;
                end
            end
        end
        retire0     = ret_a;
        retire1     = ret_b;
        arith_ready = arith_rdy;
        logic_ready = logic_rdy;
        if (!full && (written < NUM_PAIRS)) begin
            wen           = 1'b1;
            pair_in.slot0 = prog[2 * written];
            pair_in.slot1 = prog[2 * written + 1];
            written       = written + 1;
        end else begin
            wen = 1'b0;
        end
    endtask

    initial begin
        repeat (NUM_PAIRS * 40) @(posedge clk);
        $display("watchdog: run stopped after %0d cycles with %0d of %0d pairs written",
                 NUM_PAIRS * 40, written, NUM_PAIRS);
        $display("watchdog: %0d of %0d instructions dispatched", issued, NUM_INSTR);
        $display("errors: payload %0d, hazard %0d, order %0d, flow %0d",
                 payload_errs, hazard_errs, order_errs, flow_errs);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        lcg_state    = 5299;
        clk          = 1'b0;
        rst_n        = 1'b0;
        wen          = 1'b0;
        pair_in      = '0;
        arith_ready  = 1'b0;
        logic_ready  = 1'b0;
        retire0      = '0;
        retire1      = '0;
        written      = 0;
        arith_total  = 0;
        logic_total  = 0;
        payload_errs = 0;
        hazard_errs  = 0;
        order_errs   = 0;
        flow_errs    = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            flight[r] = 0;
        end
        for (int i = 0; i < NUM_INSTR; i++) begin
            prog[i] = random_bundle();
            if (prog[i].unit == UNIT_ARITH) begin
                arith_list[arith_total] = i;
                arith_total             = arith_total + 1;
            end else begin
                logic_list[logic_total] = i;
                logic_total             = logic_total + 1;
            end
        end

        repeat (8) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        assert (!arith_valid && !logic_valid && !full)
            else begin
                flow_errs = flow_errs + 1;
                $display("t=%0t: unit valids or o_full not low after reset", $time);
            end

        // with both units stalled the queue must fill up to its capacity and stop
        while (!full) begin
            step(1'b0, 1'b0);
        end
        assert (written == QUEUE_CAP)
            else begin
                flow_errs = flow_errs + 1;
                $display("t=%0t: o_full rose after %0d pairs instead of %0d",
                         $time, written, QUEUE_CAP);
            end
        repeat (10) begin
            step(1'b0, 1'b0);
        end

        while (issued < NUM_INSTR) begin
            step(rand_below(4) != 0, rand_below(4) != 0);
        end
        repeat (4) begin
            step(1'b1, 1'b1);
        end

        $display("errors: payload %0d, hazard %0d, order %0d, flow %0d",
                 payload_errs, hazard_errs, order_errs, flow_errs);
        if (payload_errs + hazard_errs + order_errs + flow_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hw/warp_issue_top.sv */
`timescale 1ns/100ps

module warp_issue_top #(
    parameter int LOG_DEPTH = 2
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_wen,
    input  issue_pkg::pair_t               i_pair,
    input  logic                           i_arith_ready,
    input  logic                           i_logic_ready,
    input  logic [issue_pkg::NUM_REGS-1:0] i_retire0,
    input  logic [issue_pkg::NUM_REGS-1:0] i_retire1,
    output logic                           o_full,
    output logic                           o_arith_valid,
    output exec_pkg::arith_payload_t       o_arith,
    output logic                           o_logic_valid,
    output exec_pkg::logic_payload_t       o_logic
);

    import issue_pkg::*;
    import exec_pkg::*;

    logic [LOG_DEPTH-1:0] wptr;
    logic [LOG_DEPTH-1:0] rptr;
    logic                 store;
    logic                 not_empty;
    pair_t                head;

    logic clear0;
    logic clear1;
    logic first_done;
    logic transmit0;
    logic transmit1;
    logic pop;
    logic arith_go;
    logic arith_slot;
    logic logic_go;
    logic logic_slot;

    arith_payload_t arith_cand0;
    arith_payload_t arith_cand1;
    logic_payload_t logic_cand0;
    logic_payload_t logic_cand1;

    queue_ptrs #(.LOG_DEPTH(LOG_DEPTH)) u_queue_ptrs (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wen       (i_wen),
        .i_pop       (pop),
        .o_wptr      (wptr),
        .o_rptr      (rptr),
        .o_full      (o_full),
        .o_not_empty (not_empty),
        .o_store     (store)
    );

    bundle_queue #(.LOG_DEPTH(LOG_DEPTH)) u_bundle_queue (
        .i_clk   (i_clk),
        .i_store (store),
        .i_wptr  (wptr),
        .i_rptr  (rptr),
        .i_pair  (i_pair),
        .o_head  (head)
    );

    scoreboard u_scoreboard (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_head       (head),
        .i_first_done (first_done),
        .i_transmit0  (transmit0),
        .i_transmit1  (transmit1),
        .i_retire0    (i_retire0),
        .i_retire1    (i_retire1),
        .o_clear0     (clear0),
        .o_clear1     (clear1)
    );

    dispatch_fsm u_dispatch_fsm (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_not_empty   (not_empty),
        .i_head        (head),
        .i_clear0      (clear0),
        .i_clear1      (clear1),
        .i_arith_ready (i_arith_ready),
        .i_logic_ready (i_logic_ready),
        .o_first_done  (first_done),
        .o_transmit0   (transmit0),
        .o_transmit1   (transmit1),
        .o_pop         (pop),
        .o_arith_go    (arith_go),
        .o_arith_slot  (arith_slot),
        .o_logic_go    (logic_go),
        .o_logic_slot  (logic_slot)
    );

    // both slots are formatted for both units, the ports pick one per cycle
    assign arith_cand0 = make_arith_payload(head.slot0, 1'b0);
    assign arith_cand1 = make_arith_payload(head.slot1, 1'b1);
    assign logic_cand0 = make_logic_payload(head.slot0, 1'b0);
    assign logic_cand1 = make_logic_payload(head.slot1, 1'b1);

    unit_port #(.payload_t(arith_payload_t)) u_arith_port (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_go      (arith_go),
        .i_slot    (arith_slot),
        .i_cand0   (arith_cand0),
        .i_cand1   (arith_cand1),
        .o_valid   (o_arith_valid),
        .o_payload (o_arith)
    );

    unit_port #(.payload_t(logic_payload_t)) u_logic_port (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_go      (logic_go),
        .i_slot    (logic_slot),
        .i_cand0   (logic_cand0),
        .i_cand1   (logic_cand1),
        .o_valid   (o_logic_valid),
        .o_payload (o_logic)
    );

endmodule

/* hw/unit_port.sv */
`timescale 1ns/100ps

module unit_port #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_go,
    input  logic     i_slot,
    input  payload_t i_cand0,
    input  payload_t i_cand1,
    output logic     o_valid,
    output payload_t o_payload
);

    payload_t sel;
    payload_t payload_q;
    logic     valid_q;

    assign sel = i_slot ? i_cand1 : i_cand0;

    // valid is a one-cycle pulse per dispatched instruction
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_go;
        end
    end

    // the payload holds its last value between dispatches
    always_ff @(posedge i_clk) begin
        if (i_go) begin
            payload_q <= sel;
        end
    end

    assign o_valid   = valid_q;
    assign o_payload = payload_q;

endmodule

/* hw/dispatch_fsm.sv */
`timescale 1ns/100ps

module dispatch_fsm (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_not_empty,
    input  issue_pkg::pair_t i_head,
    input  logic             i_clear0,
    input  logic             i_clear1,
    input  logic             i_arith_ready,
    input  logic             i_logic_ready,
    output logic             o_first_done,
    output logic             o_transmit0,
    output logic             o_transmit1,
    output logic             o_pop,
    output logic             o_arith_go,
    output logic             o_arith_slot,
    output logic             o_logic_go,
    output logic             o_logic_slot
);

    import issue_pkg::*;

    typedef enum logic {
        FIRST_PENDING  = 1'b0,
        SECOND_PENDING = 1'b1
    } state_e;

    state_e state;
    state_e state_next;

    unit_e  unit0;
    unit_e  unit1;
    logic   pending0;
    logic   ready0;
    logic   ready1;
    logic   same_cycle_ok;
    logic   s0_arith;
    logic   s1_arith;

    assign unit0 = i_head.slot0.unit;
    assign unit1 = i_head.slot1.unit;

    assign ready0 = (unit0 == UNIT_ARITH) ? i_arith_ready : i_logic_ready;
    assign ready1 = (unit1 == UNIT_ARITH) ? i_arith_ready : i_logic_ready;

    // slot0 is only still owed while the pair is in its first phase
    assign pending0 = i_not_empty && (state == FIRST_PENDING);

    assign o_transmit0 = pending0 && i_clear0 && ready0;

    // slot1 goes alongside slot0 only when the two go to different units
    // because each unit takes at most one instruction per cycle
    assign same_cycle_ok = o_transmit0 && (unit1 != unit0);

    assign o_transmit1 = i_not_empty && i_clear1 && ready1 &&
                         ((state == SECOND_PENDING) || same_cycle_ok);

    // the whole pair leaves the queue with its second instruction
    assign o_pop        = o_transmit1;
    assign o_first_done = (state == SECOND_PENDING);

    assign s0_arith = (unit0 == UNIT_ARITH);
    assign s1_arith = (unit1 == UNIT_ARITH);

    assign o_arith_go   = (o_transmit0 && s0_arith) || (o_transmit1 && s1_arith);
    assign o_arith_slot = o_transmit1 && s1_arith;
    assign o_logic_go   = (o_transmit0 && !s0_arith) || (o_transmit1 && !s1_arith);
    assign o_logic_slot = o_transmit1 && !s1_arith;

    always_comb begin
        state_next = state;
        case (state)
            FIRST_PENDING: begin
                if (o_transmit0 && !o_transmit1) begin
                    state_next = SECOND_PENDING;
                end
            end
            SECOND_PENDING: begin
                if (o_transmit1) begin
                    state_next = FIRST_PENDING;
                end
            end
            default: begin
                state_next = FIRST_PENDING;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= FIRST_PENDING;
        end else begin
            state <= state_next;
        end
    end

    // the pair whose slot0 has gone stays unchanged at the head until slot1 goes
    a_pair_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state == SECOND_PENDING) |-> (i_not_empty && $stable(i_head)))
        else $error("head pair changed while its slot1 was still pending");

endmodule

/* hw/scoreboard.sv */
`timescale 1ns/100ps

module scoreboard (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  issue_pkg::pair_t              i_head,
    input  logic                          i_first_done,
    input  logic                          i_transmit0,
    input  logic                          i_transmit1,
    input  logic [issue_pkg::NUM_REGS-1:0] i_retire0,
    input  logic [issue_pkg::NUM_REGS-1:0] i_retire1,
    output logic                          o_clear0,
    output logic                          o_clear1
);

    import issue_pkg::*;

    // one bit per register with an instruction in flight that writes it
    logic [NUM_REGS-1:0] reservation;
    logic [NUM_REGS-1:0] next_reservation;

    bundle_t             s0;
    bundle_t             s1;
    logic [NUM_REGS-1:0] s0_mask;
    logic [NUM_REGS-1:0] s1_mask;
    logic [NUM_REGS-1:0] reserve;
    logic                s1_reads_s0_rd;
    logic                pair_hazard;

    function automatic logic [NUM_REGS-1:0] reg_bit(input reg_addr_t addr);
        logic [NUM_REGS-1:0] one_hot;
        one_hot       = '0;
        one_hot[addr] = 1'b1;
        return one_hot;
    endfunction

    function automatic logic [NUM_REGS-1:0] use_mask(input bundle_t b);
        logic [NUM_REGS-1:0] rs2_bit;
        rs2_bit = b.op2_is_imm ? '0 : reg_bit(b.rs2);
        return reg_bit(b.rs1) | rs2_bit | reg_bit(b.rd);
    endfunction

    assign s0 = i_head.slot0;
    assign s1 = i_head.slot1;

    assign s0_mask = use_mask(s0);
    assign s1_mask = use_mask(s1);

    // slot1 may not read what slot0 writes in the same pair unless that is x0
    assign s1_reads_s0_rd = (s0.rd != '0) &&
                            ((s1.rs1 == s0.rd) || (!s1.op2_is_imm && (s1.rs2 == s0.rd)));

    // once slot0 has gone its rd is in the reservation, which covers the same cases
    assign pair_hazard = !i_first_done && ((s1.rd == s0.rd) || s1_reads_s0_rd);

    assign o_clear0 = ~|(reservation & s0_mask);
    assign o_clear1 = ~|(reservation & s1_mask) && !pair_hazard;

    always_comb begin
        reserve = '0;
        if (i_transmit0) begin
            reserve = reserve | reg_bit(s0.rd);
        end
        if (i_transmit1) begin
            reserve = reserve | reg_bit(s1.rd);
        end
        // x0 is hardwired and nothing ever waits on it
        reserve[0] = 1'b0;
        // a new reservation overrides a retirement of the same register
        next_reservation = (reservation & ~(i_retire0 | i_retire1)) | reserve;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reservation <= '0;
        end else begin
            reservation <= next_reservation;
        end
    end

    // dispatch may only send a slot that the hazard checks have cleared
    a_transmit_when_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_transmit0 || o_clear0) && (!i_transmit1 || o_clear1))
        else $error("slot transmitted while its registers were reserved");

endmodule

/* hw/bundle_queue.sv */
`timescale 1ns/100ps

module bundle_queue #(
    parameter int LOG_DEPTH = 2
) (
    input  logic                 i_clk,
    input  logic                 i_store,
    input  logic [LOG_DEPTH-1:0] i_wptr,
    input  logic [LOG_DEPTH-1:0] i_rptr,
    input  issue_pkg::pair_t     i_pair,
    output issue_pkg::pair_t     o_head
);

    import issue_pkg::*;

    localparam int DEPTH = 2 ** LOG_DEPTH;

    pair_t mem [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_store) begin
            mem[i_wptr] <= i_pair;
        end
    end

    // show-ahead read, so the head pair is usable in the cycle after its write
    assign o_head = mem[i_rptr];

endmodule

/* hw/queue_ptrs.sv */
`timescale 1ns/100ps

module queue_ptrs #(
    parameter int LOG_DEPTH = 2
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_wen,
    input  logic                 i_pop,
    output logic [LOG_DEPTH-1:0] o_wptr,
    output logic [LOG_DEPTH-1:0] o_rptr,
    output logic                 o_full,
    output logic                 o_not_empty,
    output logic                 o_store
);

    logic [LOG_DEPTH-1:0] wptr;
    logic [LOG_DEPTH-1:0] rptr;
    logic [LOG_DEPTH-1:0] count;

    // one entry always stays free, so equal pointers can only mean empty
    assign count       = wptr - rptr;
    assign o_full      = &count;
    assign o_not_empty = (count != '0);
    // a write that arrives while full is dropped rather than overwriting the head
    assign o_store     = i_wen && !o_full;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wptr <= '0;
        end else if (o_store) begin
            wptr <= wptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rptr <= '0;
        end else if (i_pop && o_not_empty) begin
            rptr <= rptr + 1'b1;
        end
    end

    assign o_wptr = wptr;
    assign o_rptr = rptr;

    // the decode side must watch o_full before writing
    a_no_write_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_full |-> !i_wen)
        else $error("queue written while full");

    // dispatch may only retire a pair that is actually at the head
    a_no_pop_when_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> o_not_empty)
        else $error("queue popped while empty");

endmodule

/* hw/exec_pkg.sv */
package exec_pkg;

    localparam int XLEN = 64;

    typedef struct packed {
        logic [XLEN-1:0]      imm;
        logic [2:0]           opsel;
        logic                 sub;
        logic                 unsigned_op;
        logic                 word;
        logic                 op2_is_imm;
        issue_pkg::reg_addr_t rd;
        logic                 rd_wen;
        // register read bank, 0 for slot0 operands and 1 for slot1
        logic                 banksel;
    } arith_payload_t;

    typedef struct packed {
        logic [XLEN-1:0]      imm;
        logic [2:0]           opsel;
        logic                 invert;
        logic                 word;
        logic                 op2_is_imm;
        issue_pkg::reg_addr_t rd;
        logic                 rd_wen;
        logic                 banksel;
    } logic_payload_t;

    function automatic logic [XLEN-1:0] sext_imm(
        input logic [issue_pkg::IMM_NARROW_W-1:0] imm32
    );
        return {{(XLEN - issue_pkg::IMM_NARROW_W){imm32[issue_pkg::IMM_NARROW_W-1]}}, imm32};
    endfunction

    function automatic arith_payload_t make_arith_payload(
        input issue_pkg::bundle_t b,
        input logic               slot
    );
        arith_payload_t p;
        p.imm         = sext_imm(b.imm32);
        p.opsel       = b.arith_opsel;
        p.sub         = b.arith_sub;
        p.unsigned_op = b.arith_unsigned;
        p.word        = b.arith_word;
        p.op2_is_imm  = b.op2_is_imm;
        p.rd          = b.rd;
        p.rd_wen      = b.rd_wen;
        p.banksel     = slot;
        return p;
    endfunction

    function automatic logic_payload_t make_logic_payload(
        input issue_pkg::bundle_t b,
        input logic               slot
    );
        logic_payload_t p;
        p.imm        = sext_imm(b.imm32);
        p.opsel      = b.logic_opsel;
        p.invert     = b.logic_invert;
        p.word       = b.logic_word;
        p.op2_is_imm = b.op2_is_imm;
        p.rd         = b.rd;
        p.rd_wen     = b.rd_wen;
        p.banksel    = slot;
        return p;
    endfunction

endpackage

/* hw/issue_pkg.sv */
package issue_pkg;

    // architectural register file size, x0 included
    localparam int NUM_REGS = 32;

    // immediates leave decode at this width and are widened during issue
    localparam int IMM_NARROW_W = 32;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic {
        UNIT_ARITH = 1'b0,
        UNIT_LOGIC = 1'b1
    } unit_e;

    // one decoded instruction as written by the decode side
    typedef struct packed {
        reg_addr_t                rs1;
        reg_addr_t                rs2;
        reg_addr_t                rd;
        logic [IMM_NARROW_W-1:0]  imm32;
        unit_e                    unit;
        // when set, op2 comes from the immediate and rs2 is not read
        logic                     op2_is_imm;
        logic                     rd_wen;
        logic [2:0]               arith_opsel;
        logic                     arith_sub;
        logic                     arith_unsigned;
        logic                     arith_word;
        logic [2:0]               logic_opsel;
        logic                     logic_invert;
        logic                     logic_word;
    } bundle_t;

    // slot0 is older than slot1 in program order
    typedef struct packed {
        bundle_t slot0;
        bundle_t slot1;
    } pair_t;

endpackage
